//--- source/scu_pkg.sv
/*
  Shared widths, scan register layout, CSR opcodes, addresses and bit positions.
  Bit 0 of the scan register leaves on TDO first.
*/

package scu_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int SCU_DATA_W = 4;
    localparam int SCU_ADDR_W = 2;
    localparam int SCU_OP_W   = 2;
    localparam int SCU_DR_W   = SCU_OP_W + SCU_ADDR_W + SCU_DATA_W;

    typedef logic [SCU_DATA_W-1:0] scu_data_t;
    typedef logic [SCU_ADDR_W-1:0] scu_addr_t;
    typedef logic [SCU_OP_W-1:0]   scu_op_t;

    // Scan register, opcode at the top, data at the bottom
    typedef struct packed {
        scu_op_t   op;
        scu_addr_t addr;
        scu_data_t data;
    } scu_dr_t;

    // --------------------
    // Opcodes and addresses
    // --------------------
    localparam scu_op_t SCU_OP_READ    = 2'd0;
    localparam scu_op_t SCU_OP_WRITE   = 2'd1;
    localparam scu_op_t SCU_OP_SETBITS = 2'd2;
    localparam scu_op_t SCU_OP_CLRBITS = 2'd3;

    localparam scu_addr_t SCU_ADDR_CONTROL = 2'd0;
    localparam scu_addr_t SCU_ADDR_MODE    = 2'd1;
    localparam scu_addr_t SCU_ADDR_STATUS  = 2'd2;
    localparam scu_addr_t SCU_ADDR_STICKY  = 2'd3;

    // Bit positions, CONTROL and MODE
    localparam int SCU_CTRL_SYS  = 0;
    localparam int SCU_CTRL_CORE = 1;
    localparam int SCU_MODE_DM   = 0;
    localparam int SCU_MODE_HDU  = 1;

    // Bit positions, STATUS and STICKY
    localparam int SCU_STS_SYS  = 0;
    localparam int SCU_STS_CORE = 1;
    localparam int SCU_STS_DM   = 2;
    localparam int SCU_STS_HDU  = 3;

endpackage

//--- source/scu_scan_chain.sv
/*
  Chain strobes are assumed already synchronized to clk.
  Capture, shift and update must be mutually exclusive.
*/

`timescale 1ns/10ps

module scu_scan_chain (
    input  logic               clk,
    input  logic               pwrup_rst_n_sync,
    input  logic               ch_sel_i,
    input  logic               ch_id_i,
    input  logic               ch_capture_i,
    input  logic               ch_shift_i,
    input  logic               ch_update_i,
    input  logic               ch_tdi_i,
    input  scu_pkg::scu_data_t wdata_i,
    output logic               ch_tdo_o,
    output logic               upd_o,
    output scu_pkg::scu_op_t   op_o,
    output scu_pkg::scu_addr_t addr_o,
    output scu_pkg::scu_data_t data_o
);

    import scu_pkg::*;

    logic    chain_sel;
    logic    cap_req;
    logic    shft_req;
    scu_dr_t shift_q;
    scu_dr_t shadow_q;

    // --------------------
    // Strobe decode
    // --------------------
    // Only chain 0 belongs to this unit
    assign chain_sel = ch_sel_i & (ch_id_i == 1'b0);
    assign cap_req   = chain_sel & ch_capture_i;
    assign shft_req  = chain_sel & ch_shift_i;
    assign upd_o     = chain_sel & ch_update_i;

    // Shift register, LSB out first, TDI enters at the top
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            shift_q <= '0;
        end else if (cap_req) begin
            shift_q <= shadow_q;
        end else if (shft_req) begin
            shift_q <= {ch_tdi_i, shift_q[SCU_DR_W-1:1]};
        end
    end

    // Shadow keeps last op and addr plus the data the CSR block returned
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            shadow_q <= '0;
        end else if (upd_o) begin
            shadow_q.op   <= shift_q.op;
            shadow_q.addr <= shift_q.addr;
            shadow_q.data <= wdata_i;
        end
    end

    // Fields of the shifted command
    assign op_o     = shift_q.op;
    assign addr_o   = shift_q.addr;
    assign data_o   = shift_q.data;
    assign ch_tdo_o = shift_q[0];

    // At most one chain phase at a time
    a_one_phase: assert property (
        @(posedge clk) disable iff (!pwrup_rst_n_sync)
        ch_sel_i |-> $onehot0({ch_capture_i, ch_shift_i, ch_update_i})
    ) else $error("scan chain: capture, shift and update overlap");

endmodule

//--- source/scu_csr_regs.sv
/*
  STATUS is read-only, STICKY changes only by CLRBITS or a rising status edge.
  Unused CONTROL and MODE bits read back as zero.
*/

`timescale 1ns/10ps

module scu_csr_regs (
    input  logic               clk,
    input  logic               pwrup_rst_n_sync,
    input  logic               upd_i,
    input  scu_pkg::scu_op_t   op_i,
    input  scu_pkg::scu_addr_t addr_i,
    input  scu_pkg::scu_data_t data_i,
    input  scu_pkg::scu_data_t sts_i,
    output scu_pkg::scu_data_t wdata_o,
    output scu_pkg::scu_data_t ctrl_o,
    output scu_pkg::scu_data_t mode_o
);

    import scu_pkg::*;

    // Implemented bits of CONTROL and MODE
    localparam scu_data_t CTRL_MASK = scu_data_t'((1 << SCU_CTRL_SYS) | (1 << SCU_CTRL_CORE));
    localparam scu_data_t MODE_MASK = scu_data_t'((1 << SCU_MODE_DM) | (1 << SCU_MODE_HDU));

    logic      wr_ctrl;
    logic      wr_mode;
    logic      clr_sticky;
    scu_data_t rdata;
    scu_data_t ctrl_q;
    scu_data_t mode_q;
    scu_data_t sticky_q;
    scu_data_t sts_q;
    scu_data_t sts_rise;

    // --------------------
    // Register select
    // --------------------
    // READ never modifies anything
    assign wr_ctrl    = upd_i & (op_i != SCU_OP_READ) & (addr_i == SCU_ADDR_CONTROL);
    assign wr_mode    = upd_i & (op_i != SCU_OP_READ) & (addr_i == SCU_ADDR_MODE);
    assign clr_sticky = upd_i & (op_i == SCU_OP_CLRBITS) & (addr_i == SCU_ADDR_STICKY);

    // Read mux
    always_comb begin
        rdata = '0;
        case (addr_i)
            SCU_ADDR_CONTROL: rdata = ctrl_q;
            SCU_ADDR_MODE:    rdata = mode_q;
            SCU_ADDR_STATUS:  rdata = sts_i;
            SCU_ADDR_STICKY:  rdata = sticky_q;
            default:          rdata = '0;
        endcase
    end

    // Write data, also returned into the scan shadow
    always_comb begin
        wdata_o = rdata;
        case (op_i)
            SCU_OP_WRITE:   wdata_o = data_i;
            SCU_OP_SETBITS: wdata_o = rdata | data_i;
            SCU_OP_CLRBITS: wdata_o = rdata & ~data_i;
            default:        wdata_o = rdata;
        endcase
    end

    // --------------------
    // CONTROL and MODE
    // --------------------
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            ctrl_q <= '0;
            mode_q <= '0;
        end else begin
            if (wr_ctrl) begin
                ctrl_q <= wdata_o & CTRL_MASK;
            end
            if (wr_mode) begin
                mode_q <= wdata_o & MODE_MASK;
            end
        end
    end

    assign ctrl_o = ctrl_q;
    assign mode_o = mode_q;

    // --------------------
    // STICKY
    // --------------------
    // Status delay for rising edge detect
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            sts_q <= '0;
        end else begin
            sts_q <= sts_i;
        end
    end

    assign sts_rise = sts_i & ~sts_q;

    // Edge wins over a clear on the same bit
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            sticky_q <= '0;
        end else begin
            sticky_q <= sts_rise | (clr_sticky ? wdata_o : sticky_q);
        end
    end

    // Command fields must be known when the update fires
    a_cmd_known: assert property (
        @(posedge clk) disable iff (!pwrup_rst_n_sync)
        upd_i |-> !$isunknown({op_i, addr_i})
    ) else $error("csr regs: unknown op or addr at update");

endmodule

//--- source/scu_rst_qlfy_cell.sv
/*
  Input reset must be synchronous to clk. Qualifier moves one cycle before the
  reset output on both edges, status is active high after RST_SYNC_STAGES more.
*/

`timescale 1ns/10ps

module scu_rst_qlfy_cell #(
    parameter int RST_SYNC_STAGES = 2
) (
    input  logic clk,
    input  logic pwrup_rst_n_sync,
    input  logic rst_n_in_i,
    output logic qlfy_o,
    output logic rst_n_o,
    output logic status_o
);

    logic                       qlfy_q;
    logic                       rst_q;
    logic [RST_SYNC_STAGES-1:0] sync_q;

    // --------------------
    // Qualifier then reset
    // --------------------
    // Second stage sees the change one cycle after the qualifier
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            qlfy_q <= 1'b0;
            rst_q  <= 1'b0;
        end else begin
            qlfy_q <= rst_n_in_i;
            rst_q  <= qlfy_q;
        end
    end

    assign qlfy_o  = qlfy_q;
    assign rst_n_o = rst_q;

    // Status synchronizer reads asserted until it fills
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= rst_q;
            for (int i = 1; i < RST_SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign status_o = ~sync_q[RST_SYNC_STAGES-1];

endmodule

//--- source/scu_reset_gen.sv
/*
  External resets are assumed synchronous to clk.
  DM reset has no qualifier and is released regardless of rst_n_i.
*/

`timescale 1ns/10ps

module scu_reset_gen #(
    parameter int RST_SYNC_STAGES = 2
) (
    input  logic               clk,
    input  logic               pwrup_rst_n_sync,
    input  logic               rst_n_i,
    input  logic               cpu_rst_n_i,
    input  logic               ndm_rst_n_i,
    input  logic               hart_rst_n_i,
    input  scu_pkg::scu_data_t ctrl_i,
    input  scu_pkg::scu_data_t mode_i,
    output logic               sys_rst_n_o,
    output logic               core_rst_n_o,
    output logic               dm_rst_n_o,
    output logic               hdu_rst_n_o,
    output logic               sys_rdc_qlfy_o,
    output logic               core_rdc_qlfy_o,
    output logic               hdu2dm_rdc_qlfy_o,
    output logic               sys_rst_status_o,
    output logic               core_rst_status_o,
    output scu_pkg::scu_data_t sts_o
);

    import scu_pkg::*;

    logic sys_src_n;
    logic core_src_n;
    logic hdu_src_n;
    logic dm_rst_n_q;
    logic hdu_status;

    // --------------------
    // Reset sources
    // --------------------
    // CONTROL bits are active high requests
    assign sys_src_n  = ~ctrl_i[SCU_CTRL_SYS] & ndm_rst_n_i & rst_n_i;
    assign core_src_n = sys_src_n & hart_rst_n_i & cpu_rst_n_i & ~ctrl_i[SCU_CTRL_CORE];

    // MODE HDU keeps the HDU out of core resets
    assign hdu_src_n = mode_i[SCU_MODE_HDU] | core_src_n;

    // System domain
    scu_rst_qlfy_cell #(
        .RST_SYNC_STAGES (RST_SYNC_STAGES)
    ) u_sys_cell (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_n_in_i       (sys_src_n),
        .qlfy_o           (sys_rdc_qlfy_o),
        .rst_n_o          (sys_rst_n_o),
        .status_o         (sys_rst_status_o)
    );

    // Core domain
    scu_rst_qlfy_cell #(
        .RST_SYNC_STAGES (RST_SYNC_STAGES)
    ) u_core_cell (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_n_in_i       (core_src_n),
        .qlfy_o           (core_rdc_qlfy_o),
        .rst_n_o          (core_rst_n_o),
        .status_o         (core_rst_status_o)
    );

    // HDU domain, its qualifier guards HDU to DM paths
    scu_rst_qlfy_cell #(
        .RST_SYNC_STAGES (RST_SYNC_STAGES)
    ) u_hdu_cell (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_n_in_i       (hdu_src_n),
        .qlfy_o           (hdu2dm_rdc_qlfy_o),
        .rst_n_o          (hdu_rst_n_o),
        .status_o         (hdu_status)
    );

    // --------------------
    // DM reset
    // --------------------
    // Only a system request with MODE DM set reaches the DM
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            dm_rst_n_q <= 1'b0;
        end else begin
            dm_rst_n_q <= ~mode_i[SCU_MODE_DM] | ~ctrl_i[SCU_CTRL_SYS];
        end
    end

    assign dm_rst_n_o = dm_rst_n_q;

    // Status word for the STATUS register
    always_comb begin
        sts_o               = '0;
        sts_o[SCU_STS_SYS]  = sys_rst_status_o;
        sts_o[SCU_STS_CORE] = core_rst_status_o;
        sts_o[SCU_STS_DM]   = ~dm_rst_n_q;
        sts_o[SCU_STS_HDU]  = hdu_status;
    end

endmodule

//--- source/scu_top.sv
/*
  All inputs are assumed synchronous to clk, pwrup_rst_n_sync included.
  All reset outputs and qualifiers are active low.
*/

`timescale 1ns/10ps

module scu_top #(
    parameter int RST_SYNC_STAGES = 2
) (
    input  logic clk,
    input  logic pwrup_rst_n_sync,
    input  logic rst_n_i,
    input  logic cpu_rst_n_i,
    input  logic ndm_rst_n_i,
    input  logic hart_rst_n_i,
    input  logic ch_sel_i,
    input  logic ch_id_i,
    input  logic ch_capture_i,
    input  logic ch_shift_i,
    input  logic ch_update_i,
    input  logic ch_tdi_i,
    output logic ch_tdo_o,
    output logic sys_rst_n_o,
    output logic core_rst_n_o,
    output logic dm_rst_n_o,
    output logic hdu_rst_n_o,
    output logic sys_rdc_qlfy_o,
    output logic core_rdc_qlfy_o,
    output logic hdu2dm_rdc_qlfy_o,
    output logic sys_rst_status_o,
    output logic core_rst_status_o
);

    import scu_pkg::*;

    // Scan chain to CSR block
    logic      upd;
    scu_op_t   op;
    scu_addr_t addr;
    scu_data_t data;
    scu_data_t wdata;

    // CSR block to and from reset generator
    scu_data_t ctrl;
    scu_data_t mode;
    scu_data_t sts;

    scu_scan_chain u_scan_chain (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .ch_sel_i         (ch_sel_i),
        .ch_id_i          (ch_id_i),
        .ch_capture_i     (ch_capture_i),
        .ch_shift_i       (ch_shift_i),
        .ch_update_i      (ch_update_i),
        .ch_tdi_i         (ch_tdi_i),
        .wdata_i          (wdata),
        .ch_tdo_o         (ch_tdo_o),
        .upd_o            (upd),
        .op_o             (op),
        .addr_o           (addr),
        .data_o           (data)
    );

    scu_csr_regs u_csr_regs (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .upd_i            (upd),
        .op_i             (op),
        .addr_i           (addr),
        .data_i           (data),
        .sts_i            (sts),
        .wdata_o          (wdata),
        .ctrl_o           (ctrl),
        .mode_o           (mode)
    );

    scu_reset_gen #(
        .RST_SYNC_STAGES (RST_SYNC_STAGES)
    ) u_reset_gen (
        .clk               (clk),
        .pwrup_rst_n_sync  (pwrup_rst_n_sync),
        .rst_n_i           (rst_n_i),
        .cpu_rst_n_i       (cpu_rst_n_i),
        .ndm_rst_n_i       (ndm_rst_n_i),
        .hart_rst_n_i      (hart_rst_n_i),
        .ctrl_i            (ctrl),
        .mode_i            (mode),
        .sys_rst_n_o       (sys_rst_n_o),
        .core_rst_n_o      (core_rst_n_o),
        .dm_rst_n_o        (dm_rst_n_o),
        .hdu_rst_n_o       (hdu_rst_n_o),
        .sys_rdc_qlfy_o    (sys_rdc_qlfy_o),
        .core_rdc_qlfy_o   (core_rdc_qlfy_o),
        .hdu2dm_rdc_qlfy_o (hdu2dm_rdc_qlfy_o),
        .sys_rst_status_o  (sys_rst_status_o),
        .core_rst_status_o (core_rst_status_o),
        .sts_o             (sts)
    );

endmodule

//--- sim/tb_scu.sv
/*
  Runs scan and wait entries from sim/scu_testdata.txt against scu_top.
  Inputs move 1 ns after the rising edge. Outputs are sampled there too.
*/

`timescale 1ns/10ps

module tb_scu;

    logic clk;
    logic pwrup_rst_n_sync;
    logic rst_n_i;
    logic cpu_rst_n_i;
    logic ndm_rst_n_i;
    logic hart_rst_n_i;
    logic ch_sel_i;
    logic ch_id_i;
    logic ch_capture_i;
    logic ch_shift_i;
    logic ch_update_i;
    logic ch_tdi_i;
    logic ch_tdo_o;
    logic sys_rst_n_o;
    logic core_rst_n_o;
    logic dm_rst_n_o;
    logic hdu_rst_n_o;
    logic sys_rdc_qlfy_o;
    logic core_rdc_qlfy_o;
    logic hdu2dm_rdc_qlfy_o;
    logic sys_rst_status_o;
    logic core_rst_status_o;

    // One entry per line with the kind in the top digit
    logic [23:0] test_mem [0:63];
    int          n_tests;
    int          err_count;
    int          check_count;
    int          cycle_count;
    int          cycle_limit;
    logic        sys_rst_prev;
    logic        hdu_rst_prev;

    scu_top u_scu_top (
        .clk               (clk),
        .pwrup_rst_n_sync  (pwrup_rst_n_sync),
        .rst_n_i           (rst_n_i),
        .cpu_rst_n_i       (cpu_rst_n_i),
        .ndm_rst_n_i       (ndm_rst_n_i),
        .hart_rst_n_i      (hart_rst_n_i),
        .ch_sel_i          (ch_sel_i),
        .ch_id_i           (ch_id_i),
        .ch_capture_i      (ch_capture_i),
        .ch_shift_i        (ch_shift_i),
        .ch_update_i       (ch_update_i),
        .ch_tdi_i          (ch_tdi_i),
        .ch_tdo_o          (ch_tdo_o),
        .sys_rst_n_o       (sys_rst_n_o),
        .core_rst_n_o      (core_rst_n_o),
        .dm_rst_n_o        (dm_rst_n_o),
        .hdu_rst_n_o       (hdu_rst_n_o),
        .sys_rdc_qlfy_o    (sys_rdc_qlfy_o),
        .core_rdc_qlfy_o   (core_rdc_qlfy_o),
        .hdu2dm_rdc_qlfy_o (hdu2dm_rdc_qlfy_o),
        .sys_rst_status_o  (sys_rst_status_o),
        .core_rst_status_o (core_rst_status_o)
    );

    // --------------------
    // Clock and helpers
    // --------------------
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("mismatch %s: got 0x%02h, expected 0x%02h at %0t", name, got, exp, $time);
        end
    endtask

    // Lands 1 ns past the edge where inputs change
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    // Shift in, update, capture, shift out the shadow
    task automatic scan_transaction(input logic chain_id, input logic [7:0] cmd,
                                    output logic [7:0] rd);
        int i;
        ch_sel_i   = 1'b1;
        ch_id_i    = chain_id;
        ch_shift_i = 1'b1;
        for (i = 0; i < 8; i++) begin
            ch_tdi_i = cmd[i];
            step_cycle();
        end
        ch_shift_i  = 1'b0;
        ch_tdi_i    = 1'b0;
        ch_update_i = 1'b1;
        step_cycle();
        ch_update_i  = 1'b0;
        ch_capture_i = 1'b1;
        step_cycle();
        ch_capture_i = 1'b0;
        ch_shift_i   = 1'b1;
        // Bit 0 is already on TDO after capture
        for (i = 0; i < 8; i++) begin
            rd[i] = ch_tdo_o;
            step_cycle();
        end
        ch_shift_i = 1'b0;
        ch_sel_i   = 1'b0;
        ch_id_i    = 1'b0;
    endtask

    // Reset outputs, qualifiers and status packed as in the data file
    function automatic logic [7:0] output_pattern();
        return {core_rst_status_o, sys_rst_status_o, core_rdc_qlfy_o, sys_rdc_qlfy_o,
                hdu_rst_n_o, dm_rst_n_o, core_rst_n_o, sys_rst_n_o};
    endfunction

    // --------------------
    // Qualifier ordering monitor
    // --------------------
    always @(negedge clk) begin
        if (pwrup_rst_n_sync && sys_rst_prev && !sys_rst_n_o) begin
            check_value("sys_rdc_qlfy_o at sys reset fall", {7'd0, sys_rdc_qlfy_o}, 8'h00);
        end
        if (pwrup_rst_n_sync && hdu_rst_prev && !hdu_rst_n_o) begin
            check_value("hdu2dm_rdc_qlfy_o at hdu reset fall", {7'd0, hdu2dm_rdc_qlfy_o},
                        8'h00);
        end
        sys_rst_prev = sys_rst_n_o;
        hdu_rst_prev = hdu_rst_n_o;
    end

    // Timeout once the limit is known
    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the run did not finish", cycle_count);
        $display("Test failed");
        $finish;
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int          t;
        int          errs_before;
        logic [23:0] entry;
        logic [7:0]  cmd;
        logic [7:0]  rd;
        logic        chain_id;
        pwrup_rst_n_sync = 1'b0;
        rst_n_i          = 1'b1;
        cpu_rst_n_i      = 1'b1;
        ndm_rst_n_i      = 1'b1;
        hart_rst_n_i     = 1'b1;
        ch_sel_i         = 1'b0;
        ch_id_i          = 1'b0;
        ch_capture_i     = 1'b0;
        ch_shift_i       = 1'b0;
        ch_update_i      = 1'b0;
        ch_tdi_i         = 1'b0;
        sys_rst_prev     = 1'b0;
        hdu_rst_prev     = 1'b0;
        err_count        = 0;
        check_count      = 0;
        cycle_limit      = 0;
        // End markers everywhere tagged with the address
        for (t = 0; t < 64; t++) begin
            test_mem[t] = 24'hF00000 | 24'(t);
        end
        $readmemh("sim/scu_testdata.txt", test_mem);
        n_tests = 0;
        while (n_tests < 64 && test_mem[n_tests][23:20] != 4'hF) begin
            n_tests++;
        end
        cycle_limit = n_tests * 40 + 100;
        if (n_tests == 0) begin
            err_count++;
            $display("no tests found in sim/scu_testdata.txt");
        end
        repeat (2) @(posedge clk);
        #1;
        pwrup_rst_n_sync = 1'b1;
        for (t = 0; t < n_tests; t++) begin
            entry       = test_mem[t];
            errs_before = err_count;
            cmd         = {entry[17:16], entry[13:12], entry[11:8]};
            chain_id    = (entry[23:20] == 4'h2);
            if (entry[23:20] == 4'h1) begin
                repeat (int'(entry[11:8])) step_cycle();
                check_value("reset outputs", output_pattern(), entry[7:0]);
                $display("test %0d wait %0d cycles: %s", t + 1, entry[11:8],
                         (err_count == errs_before) ? "ok" : "error");
            end else begin
                scan_transaction(chain_id, cmd, rd);
                // Entries on a foreign chain id are checked by the read that follows
                if (entry[23:20] == 4'h0) begin
                    check_value("ch_tdo_o op", {6'd0, rd[7:6]}, {6'd0, cmd[7:6]});
                    check_value("ch_tdo_o addr", {6'd0, rd[5:4]}, {6'd0, cmd[5:4]});
                    check_value("ch_tdo_o data", {4'd0, rd[3:0]}, {4'd0, entry[3:0]});
                end
                $display("test %0d scan id %0d op %0d addr %0d data 0x%h: %s", t + 1,
                         chain_id, cmd[7:6], cmd[5:4], cmd[3:0],
                         (err_count == errs_before) ? "ok" : "error");
            end
        end
        $display("tests %0d, checks %0d, errors %0d", n_tests, check_count, err_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- sim/scu_testdata.txt
// Hex digits: kind, op, addr, data, expected (two digits)
// Kind 0 scan, 1 wait (data = cycles, expected = output pattern), 2 scan on chain id 1, F end
10083F // all resets released after power-up
00300F // read STICKY, every status fell after power-up
033F00 // clear all STICKY bits
003000 // read STICKY
011303 // write MODE
001003 // read MODE back
011000 // write MODE to zero
020111 // set CONTROL system bit
1002C4 // system, core and HDU in reset
020233 // set CONTROL core bit on top
030102 // clear CONTROL system bit
100295 // core and HDU still in reset
030200 // clear CONTROL core bit
10043F // everything released
011101 // MODE DM
020111 // set CONTROL system bit
1002C0 // DM reset joins in
030100 // clear CONTROL system bit
011202 // MODE HDU
020222 // set CONTROL core bit
10029D // HDU held out of core reset
030200 // clear CONTROL core bit
011000 // MODE back to zero
10043F // everything released
033F00 // clear all STICKY bits
020222 // core reset pulse on
030200 // core reset pulse off
00300A // STICKY shows core and HDU
033208 // clear the core bit only
003008 // HDU bit still set
211303 // write MODE on chain id 1
001000 // MODE unchanged
F00000 // end

//--- all.f
source/scu_pkg.sv
source/scu_scan_chain.sv
source/scu_csr_regs.sv
source/scu_rst_qlfy_cell.sv
source/scu_reset_gen.sv
source/scu_top.sv
sim/tb_scu.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP      = tb_scu
FILELIST = all.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
